// ==== include/trace_cfg.svh ====
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// trace unit configuration
//////////////////////////////////////////////////////////////////////

// data and address width of the traced core
`define TRACE_XLEN 32

// width of the free running cycle counter
`define TRACE_CYCLE_W 32

// records held per stage queue, power of two
`define TRACE_QUEUE_DEPTH 4

`endif

// ==== tb/trace_unit_tb.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_unit_tb import trace_pkg::*; ();

  // one stimulus row with its expected decode fields
  typedef struct packed {
    logic [31:0]  pc;
    logic [31:0]  instr;
    logic [3:0]   ex_wait;
    logic         ex_wr;
    logic         mem_acc;
    logic         bypass;
    logic [3:0]   wb_wait;
    logic         wb_wr;
    instr_class_e iclass;
    reg_idx_t     rd;
    logic         has_rd;
  } stim_row_t;

  logic        clk;
  logic        rst_n;
  logic        id_valid;
  logic        is_decoding;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        ex_valid;
  logic        wb_bypass;
  logic        ex_reg_we;
  reg_idx_t    ex_reg_addr;
  logic [31:0] ex_reg_wdata;
  logic        ex_data_req;
  logic        ex_data_gnt;
  logic        ex_data_we;
  logic [31:0] ex_data_addr;
  logic        wb_valid;
  logic        wb_reg_we;
  reg_idx_t    wb_reg_addr;
  logic [31:0] wb_reg_wdata;
  logic        trace_valid;
  trace_rec_t  trace_rec;
  logic        overflow;

  stim_row_t  rows [$];
  trace_rec_t pend [16];
  trace_rec_t exp_recs [$];
  int         exp_edges [$];
  int         edge_cnt;
  int         errors = 0;
  int         timeouts = 0;

  trace_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // mirrors the rule for the cycle stamp
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      edge_cnt <= 0;
    else
      edge_cnt <= edge_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic compare_rec(input trace_rec_t want, input int want_edge);
    check_val("cycle", trace_rec.cycle, want.cycle);
    check_val("pc", trace_rec.pc, want.pc);
    check_val("instr", trace_rec.instr, want.instr);
    check_val("iclass", trace_rec.iclass, want.iclass);
    check_val("rd", trace_rec.rd, want.rd);
    check_val("has_rd", trace_rec.has_rd, want.has_rd);
    check_val("rd_value", trace_rec.rd_value, want.rd_value);
    check_val("mem_valid", trace_rec.mem_valid, want.mem_valid);
    check_val("mem_we", trace_rec.mem_we, want.mem_we);
    check_val("mem_addr", trace_rec.mem_addr, want.mem_addr);
    check_val("trace_valid cycle", edge_cnt, want_edge);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && trace_valid) begin
      if (exp_recs.size() == 0) begin
        $display("unexpected trace record at %0t with nothing in flight", $time);
        errors++;
      end else begin
        compare_rec(exp_recs.pop_front(), exp_edges.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic tick;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pc           = '0;
    instr        = '0;
    ex_valid     = 1'b0;
    wb_bypass    = 1'b0;
    ex_reg_we    = 1'b0;
    ex_reg_addr  = '0;
    ex_reg_wdata = '0;
    ex_data_req  = 1'b0;
    ex_data_gnt  = 1'b0;
    ex_data_we   = 1'b0;
    ex_data_addr = '0;
    wb_valid     = 1'b0;
    wb_reg_we    = 1'b0;
    wb_reg_addr  = '0;
    wb_reg_wdata = '0;
  endtask

  task automatic add_row(input logic [31:0] r_pc, input logic [31:0] r_instr,
                         input int ex_w, input int ex_wr, input int mem, input int byp,
                         input int wb_w, input int wb_wr, input instr_class_e cls,
                         input int rd, input int has_rd);
    stim_row_t r;
    r.pc      = r_pc;
    r.instr   = r_instr;
    r.ex_wait = 4'(ex_w);
    r.ex_wr   = (ex_wr != 0);
    r.mem_acc = (mem != 0);
    r.bypass  = (byp != 0);
    r.wb_wait = 4'(wb_w);
    r.wb_wr   = (wb_wr != 0);
    r.iclass  = cls;
    r.rd      = reg_idx_t'(rd);
    r.has_rd  = (has_rd != 0);
    rows.push_back(r);
  endtask

  // pc, instr, ex wait, ex write, mem, bypass, wb wait, wb write, class, rd, has_rd
  task automatic load_table;
    add_row(32'h0000_1000, 32'h1234_52B7, 3, 1, 0, 0, 2, 0, cls_lui,     5, 1);
    add_row(32'h0000_1004, 32'h0000_1017, 3, 1, 0, 0, 2, 1, cls_auipc,   0, 0);
    add_row(32'h0000_1008, 32'h0080_00EF, 4, 0, 0, 0, 2, 0, cls_jal,     1, 1);
    add_row(32'h0000_100C, 32'h0000_83E7, 3, 1, 0, 0, 3, 1, cls_jalr,    7, 1);
    add_row(32'h0000_1010, 32'h0020_8463, 3, 0, 0, 1, 2, 0, cls_branch,  8, 0);
    add_row(32'h0000_1014, 32'h0041_2503, 5, 0, 1, 0, 2, 1, cls_load,   10, 1);
    add_row(32'h0000_1018, 32'h0031_2423, 3, 0, 1, 0, 2, 0, cls_store,   8, 0);
    add_row(32'h0000_101C, 32'h0050_0613, 3, 1, 0, 0, 2, 0, cls_op_imm, 12, 1);
    add_row(32'h0000_1020, 32'h0020_8FB3, 4, 1, 0, 0, 3, 1, cls_op,     31, 1);
    add_row(32'h0000_1024, 32'h0FF0_000F, 3, 0, 0, 0, 2, 0, cls_fence,   0, 0);
    add_row(32'h0000_1028, 32'h3000_1373, 3, 1, 0, 0, 2, 0, cls_system,  6, 1);
    add_row(32'h0000_102C, 32'h0000_0073, 3, 1, 0, 0, 2, 1, cls_system,  0, 0);
    add_row(32'h0000_1030, 32'h1234_5678, 3, 0, 0, 0, 2, 0, cls_invalid, 12, 0);
    add_row(32'h0000_1034, 32'h0000_0F0B, 3, 1, 0, 0, 2, 0, cls_invalid, 30, 0);
  endtask

  task automatic accept_row(input int i);
    id_valid    = 1'b1;
    is_decoding = 1'b1;
    pc          = rows[i].pc;
    instr       = rows[i].instr;
    pend[i]        = '0;
    pend[i].cycle  = edge_cnt;
    pend[i].pc     = rows[i].pc;
    pend[i].instr  = rows[i].instr;
    pend[i].iclass = rows[i].iclass;
    pend[i].rd     = rows[i].rd;
    pend[i].has_rd = rows[i].has_rd;
    tick();
    idle_inputs();
  endtask

  task automatic ex_row(input int i);
    stim_row_t   r;
    logic [31:0] data;
    r = rows[i];
    for (int k = 0; k < r.ex_wait; k++) begin
      if (k == 0) begin
        // other register and a request without grant
        ex_reg_we    = 1'b1;
        ex_reg_addr  = r.rd ^ 5'd1;
        ex_reg_wdata = $urandom;
        ex_data_req  = 1'b1;
        ex_data_addr = $urandom;
      end else if (k == 1) begin
        if (r.ex_wr) begin
          data         = $urandom;
          ex_reg_we    = 1'b1;
          ex_reg_addr  = r.rd;
          ex_reg_wdata = data;
          if (r.has_rd)
            pend[i].rd_value = data;
        end
        if (r.mem_acc) begin
          ex_data_req  = 1'b1;
          ex_data_gnt  = 1'b1;
          ex_data_we   = (r.iclass == cls_store);
          ex_data_addr = $urandom;
          pend[i].mem_valid = 1'b1;
          pend[i].mem_we    = ex_data_we;
          pend[i].mem_addr  = ex_data_addr;
        end
      end else if (k == 2 && r.mem_acc) begin
        // a second grant that must be ignored
        ex_data_req  = 1'b1;
        ex_data_gnt  = 1'b1;
        ex_data_we   = (r.iclass != cls_store);
        ex_data_addr = $urandom;
      end
      tick();
      idle_inputs();
    end
    if (r.bypass)
      wb_bypass = 1'b1;
    else
      ex_valid = 1'b1;
    tick();
    idle_inputs();
  endtask

  task automatic wb_row(input int i);
    stim_row_t   r;
    logic [31:0] data;
    r = rows[i];
    for (int k = 0; k < r.wb_wait; k++) begin
      if (k == 0) begin
        wb_reg_we    = 1'b1;
        wb_reg_addr  = r.rd ^ 5'd1;
        wb_reg_wdata = $urandom;
      end else if (k == 1 && r.wb_wr) begin
        data         = $urandom;
        wb_reg_we    = 1'b1;
        wb_reg_addr  = r.rd;
        wb_reg_wdata = data;
        if (r.has_rd)
          pend[i].rd_value = data;
      end
      tick();
      idle_inputs();
    end
    // record is due one cycle after this strobe
    wb_valid = 1'b1;
    exp_recs.push_back(pend[i]);
    exp_edges.push_back(edge_cnt + 1);
    tick();
    idle_inputs();
  endtask

  task automatic wait_drain;
    int n;
    n = 0;
    while (exp_recs.size() != 0 && n < 200) begin
      tick();
      n++;
    end
    if (exp_recs.size() != 0) begin
      $display("timeout at %0t: trace record missing after 200 cycles", $time);
      timeouts++;
      exp_recs.delete();
      exp_edges.delete();
    end
  endtask

  // several in flight with optional dropped acceptances
  task automatic run_burst(input int first, input int n, input int drop);
    for (int j = 0; j < n + drop; j++)
      accept_row(first + j);
    check_val("overflow", overflow, (drop != 0));
    for (int j = 0; j < n; j++)
      ex_row(first + j);
    for (int j = 0; j < n; j++)
      wb_row(first + j);
    wait_drain();
    check_val("overflow", overflow, (drop != 0));
  endtask

  task automatic apply_reset;
    rst_n = 1'b0;
    idle_inputs();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_val("trace_valid after reset", trace_valid, 1'b0);
    check_val("overflow after reset", overflow, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h3492_1359));
    rst_n = 1'b0;
    idle_inputs();
    load_table();
    apply_reset();

    // id_valid without is_decoding is no acceptance
    id_valid = 1'b1;
    tick();
    idle_inputs();

    for (int i = 0; i < rows.size(); i++) begin
      accept_row(i);
      ex_row(i);
      wb_row(i);
      wait_drain();
    end
    check_val("overflow", overflow, 1'b0);

    // strobes with empty queues
    wb_valid  = 1'b1;
    ex_valid  = 1'b1;
    wb_bypass = 1'b1;
    tick();
    idle_inputs();
    repeat (3) tick();

    run_burst(4, 3, 0);
    run_burst(0, `TRACE_QUEUE_DEPTH, 1);
    apply_reset();

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== trace_unit.f ====
+incdir+include
verilog/trace_pkg.sv
verilog/trace_fifo.sv
verilog/trace_decoder.sv
verilog/trace_ex_stage.sv
verilog/trace_wb_stage.sv
verilog/trace_unit.sv
tb/trace_unit_tb.sv

// ==== verilog/trace_decoder.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_decoder import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic [`TRACE_XLEN-1:0] pc,
  input  logic [31:0]            instr,
  input  logic                   q_full,
  output logic                   push,
  output trace_rec_t             rec,
  output logic                   overflow
);

  logic [`TRACE_CYCLE_W-1:0] cycle_q;
  logic                      ovf_q;
  logic                      accept;
  instr_class_e              iclass;
  reg_idx_t                  rd;
  logic                      writes_rd;

  assign accept = id_valid & is_decoding;
  assign rd     = instr[11:7];

  // major class from the opcode field
  always_comb begin
    iclass = cls_invalid;
    if (instr[1:0] == 2'b11) begin
      case (rv_opcode_e'(instr[6:0]))
        lui:      iclass = cls_lui;
        auipc:    iclass = cls_auipc;
        jal:      iclass = cls_jal;
        jalr:     iclass = cls_jalr;
        branch:   iclass = cls_branch;
        load:     iclass = cls_load;
        store:    iclass = cls_store;
        op_imm:   iclass = cls_op_imm;
        op:       iclass = cls_op;
        misc_mem: iclass = cls_fence;
        system:   iclass = cls_system;
        default:  iclass = cls_invalid;
      endcase
    end
  end

  // csr accesses write rd, ecall/ebreak/xret do not
  always_comb begin
    case (iclass)
      cls_lui, cls_auipc, cls_jal, cls_jalr,
      cls_load, cls_op_imm, cls_op: writes_rd = 1'b1;
      cls_system:                   writes_rd = (instr[14:12] != 3'b000);
      default:                      writes_rd = 1'b0;
    endcase
  end

  // initial record, annotations filled in later
  always_comb begin
    rec        = '0;
    rec.cycle  = cycle_q;
    rec.pc     = pc;
    rec.instr  = instr;
    rec.iclass = iclass;
    rec.rd     = rd;
    rec.has_rd = writes_rd && (rd != '0);
  end

  assign push     = accept;
  assign overflow = ovf_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
      ovf_q   <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      // dropped instruction, sticky until reset
      if (accept && q_full)
        ovf_q <= 1'b1;
    end
  end

endmodule

// ==== verilog/trace_ex_stage.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_ex_stage import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  trace_rec_t             head,
  input  logic                   empty,
  input  logic                   ex_valid,
  input  logic                   wb_bypass,
  input  logic                   ex_reg_we,
  input  reg_idx_t               ex_reg_addr,
  input  logic [`TRACE_XLEN-1:0] ex_reg_wdata,
  input  logic                   ex_data_req,
  input  logic                   ex_data_gnt,
  input  logic                   ex_data_we,
  input  logic [`TRACE_XLEN-1:0] ex_data_addr,
  input  logic                   next_full,
  output logic                   pop,
  output logic                   push,
  output trace_rec_t             push_rec,
  output logic                   overflow
);

  trace_rec_t             merged;
  logic                   reg_hit;
  logic                   mem_hit;
  logic                   advance;
  logic                   rd_upd_q;
  logic [`TRACE_XLEN-1:0] rd_val_q;
  logic                   mem_valid_q;
  logic                   mem_we_q;
  logic [`TRACE_XLEN-1:0] mem_addr_q;
  logic                   ovf_q;

  assign reg_hit = ex_reg_we && head.has_rd && (ex_reg_addr == head.rd);
  assign mem_hit = ex_data_req && ex_data_gnt && !mem_valid_q && !head.mem_valid;
  // branches leave EX through the bypass
  assign advance = (ex_valid || wb_bypass) && !empty;

  //////////////////////////////////////////////////////////////////////
  // annotations merged over the queue head
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    merged = head;
    if (rd_upd_q)
      merged.rd_value = rd_val_q;
    if (reg_hit)
      merged.rd_value = ex_reg_wdata;
    if (mem_valid_q) begin
      merged.mem_valid = 1'b1;
      merged.mem_we    = mem_we_q;
      merged.mem_addr  = mem_addr_q;
    end else if (mem_hit) begin
      merged.mem_valid = 1'b1;
      merged.mem_we    = ex_data_we;
      merged.mem_addr  = ex_data_addr;
    end
  end

  assign pop      = advance;
  assign push     = advance;
  assign push_rec = merged;
  assign overflow = ovf_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_upd_q    <= 1'b0;
      mem_valid_q <= 1'b0;
      ovf_q       <= 1'b0;
    end else begin
      if (advance) begin
        rd_upd_q    <= 1'b0;
        mem_valid_q <= 1'b0;
      end else if (!empty) begin
        rd_upd_q    <= rd_upd_q | reg_hit;
        mem_valid_q <= merged.mem_valid;
      end
      // writeback queue full, record lost
      if (advance && next_full)
        ovf_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!empty) begin
      rd_val_q   <= merged.rd_value;
      mem_we_q   <= merged.mem_we;
      mem_addr_q <= merged.mem_addr;
    end
  end

endmodule

// ==== verilog/trace_fifo.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_fifo import trace_pkg::*; #(
  parameter int DEPTH = `TRACE_QUEUE_DEPTH
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  trace_rec_t push_rec,
  input  logic       pop,
  output trace_rec_t head,
  output logic       empty,
  output logic       full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  trace_rec_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // show-ahead, head valid while not empty
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_rec;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/trace_pkg.sv ====
`include "trace_cfg.svh"

package trace_pkg;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    lui      = 7'b0110111,
    auipc    = 7'b0010111,
    jal      = 7'b1101111,
    jalr     = 7'b1100111,
    branch   = 7'b1100011,
    load     = 7'b0000011,
    store    = 7'b0100011,
    op_imm   = 7'b0010011,
    op       = 7'b0110011,
    misc_mem = 7'b0001111,
    system   = 7'b1110011
  } rv_opcode_e;

  // major instruction classes as seen in the trace
  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_op_imm,
    cls_op,
    cls_fence,
    cls_system,
    cls_invalid
  } instr_class_e;

  typedef logic [4:0] reg_idx_t;

  // one record per accepted instruction
  typedef struct packed {
    logic [`TRACE_CYCLE_W-1:0] cycle;
    logic [`TRACE_XLEN-1:0]    pc;
    logic [31:0]               instr;
    instr_class_e              iclass;
    reg_idx_t                  rd;
    logic                      has_rd;
    logic [`TRACE_XLEN-1:0]    rd_value;
    logic                      mem_valid;
    logic                      mem_we;
    logic [`TRACE_XLEN-1:0]    mem_addr;
  } trace_rec_t;

endpackage

// ==== verilog/trace_unit.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_unit import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // decode
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic [`TRACE_XLEN-1:0] pc,
  input  logic [31:0]            instr,
  // execute
  input  logic                   ex_valid,
  input  logic                   wb_bypass,
  input  logic                   ex_reg_we,
  input  reg_idx_t               ex_reg_addr,
  input  logic [`TRACE_XLEN-1:0] ex_reg_wdata,
  input  logic                   ex_data_req,
  input  logic                   ex_data_gnt,
  input  logic                   ex_data_we,
  input  logic [`TRACE_XLEN-1:0] ex_data_addr,
  // writeback
  input  logic                   wb_valid,
  input  logic                   wb_reg_we,
  input  reg_idx_t               wb_reg_addr,
  input  logic [`TRACE_XLEN-1:0] wb_reg_wdata,
  // trace output
  output logic                   trace_valid,
  output trace_rec_t             trace_rec,
  output logic                   overflow
);

  logic       dec_push;
  trace_rec_t dec_rec;
  logic       dec_ovf;
  trace_rec_t id_ex_head;
  logic       id_ex_empty;
  logic       id_ex_full;
  logic       ex_pop;
  logic       ex_push;
  trace_rec_t ex_rec;
  logic       ex_ovf;
  trace_rec_t ex_wb_head;
  logic       ex_wb_empty;
  logic       ex_wb_full;
  logic       wb_pop;

  trace_decoder u_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pc          (pc),
    .instr       (instr),
    .q_full      (id_ex_full),
    .push        (dec_push),
    .rec         (dec_rec),
    .overflow    (dec_ovf)
  );

  trace_fifo id_ex_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (dec_push),
    .push_rec (dec_rec),
    .pop      (ex_pop),
    .head     (id_ex_head),
    .empty    (id_ex_empty),
    .full     (id_ex_full)
  );

  trace_ex_stage u_ex_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .head         (id_ex_head),
    .empty        (id_ex_empty),
    .ex_valid     (ex_valid),
    .wb_bypass    (wb_bypass),
    .ex_reg_we    (ex_reg_we),
    .ex_reg_addr  (ex_reg_addr),
    .ex_reg_wdata (ex_reg_wdata),
    .ex_data_req  (ex_data_req),
    .ex_data_gnt  (ex_data_gnt),
    .ex_data_we   (ex_data_we),
    .ex_data_addr (ex_data_addr),
    .next_full    (ex_wb_full),
    .pop          (ex_pop),
    .push         (ex_push),
    .push_rec     (ex_rec),
    .overflow     (ex_ovf)
  );

  trace_fifo ex_wb_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (ex_push),
    .push_rec (ex_rec),
    .pop      (wb_pop),
    .head     (ex_wb_head),
    .empty    (ex_wb_empty),
    .full     (ex_wb_full)
  );

  trace_wb_stage u_wb_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .head         (ex_wb_head),
    .empty        (ex_wb_empty),
    .wb_valid     (wb_valid),
    .wb_reg_we    (wb_reg_we),
    .wb_reg_addr  (wb_reg_addr),
    .wb_reg_wdata (wb_reg_wdata),
    .pop          (wb_pop),
    .trace_valid  (trace_valid),
    .trace_rec    (trace_rec)
  );

  // lost records at either queue
  assign overflow = dec_ovf | ex_ovf;

endmodule

// ==== verilog/trace_wb_stage.sv ====
`timescale 1ns/10ps
`include "trace_cfg.svh"

module trace_wb_stage import trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  trace_rec_t             head,
  input  logic                   empty,
  input  logic                   wb_valid,
  input  logic                   wb_reg_we,
  input  reg_idx_t               wb_reg_addr,
  input  logic [`TRACE_XLEN-1:0] wb_reg_wdata,
  output logic                   pop,
  output logic                   trace_valid,
  output trace_rec_t             trace_rec
);

  trace_rec_t             merged;
  logic                   reg_hit;
  logic                   retire;
  logic                   rd_upd_q;
  logic [`TRACE_XLEN-1:0] rd_val_q;

  assign reg_hit = wb_reg_we && head.has_rd && (wb_reg_addr == head.rd);
  assign retire  = wb_valid && !empty;

  // pending writeback value wins over the EX value
  always_comb begin
    merged = head;
    if (rd_upd_q)
      merged.rd_value = rd_val_q;
    if (reg_hit)
      merged.rd_value = wb_reg_wdata;
  end

  assign pop = retire;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_upd_q    <= 1'b0;
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= retire;
      if (retire)
        rd_upd_q <= 1'b0;
      else if (!empty)
        rd_upd_q <= rd_upd_q | reg_hit;
    end
  end

  // finished record and pending value
  always_ff @(posedge clk) begin
    if (retire)
      trace_rec <= merged;
    if (!empty)
      rd_val_q <= merged.rd_value;
  end

endmodule
